/* hdl/ocd_pkg.sv */
package ocd_pkg;

    // ==========================================================
    // stream and frame geometry
    // ==========================================================
    localparam int BYTE_W      = 8;
    localparam int FRAME_LEN   = 12;
    localparam int SYNC_LEN    = 3;
    localparam int CRC_LEN     = 2;

    // bytes after the sync pattern, CRC included
    localparam int BODY_LEN    = FRAME_LEN - SYNC_LEN;
    // type, address and data bytes only
    localparam int FIELD_LEN   = BODY_LEN - CRC_LEN;
    localparam int BODY_CNT_W  = $clog2(BODY_LEN);

    localparam int ADDR_W      = 16;
    localparam int WORD_ADDR_W = 14;
    localparam int DATA_W      = 32;
    localparam int TYPE_W      = 7;
    // type, toggle, address, data
    localparam int PAYLOAD_W   = TYPE_W + 1 + ADDR_W + DATA_W;

    // ==========================================================
    // sync pattern, in arrival order
    // ==========================================================
    localparam logic [BYTE_W-1:0] SYNC_2 = 8'h5A;
    localparam logic [BYTE_W-1:0] SYNC_1 = 8'hA5;
    localparam logic [BYTE_W-1:0] SYNC_0 = 8'h01;

    // CRC-16-CCITT, MSB first, residue zero on a good frame
    localparam logic [15:0] CRC_POLY = 16'h1021;
    localparam logic [15:0] CRC_INIT = 16'hFFFF;

    // ==========================================================
    // frame types and reply opcodes
    // ==========================================================
    localparam logic [TYPE_W-1:0] TYPE_WRITE_NOACK = 7'd1;
    localparam logic [TYPE_W-1:0] TYPE_WRITE_ACK   = 7'd2;
    localparam logic [TYPE_W-1:0] TYPE_READ        = 7'd3;
    localparam logic [TYPE_W-1:0] TYPE_CPU_RESET   = 7'd4;
    localparam logic [TYPE_W-1:0] TYPE_UART_SEL    = 7'd5;

    // bit positions in the one-hot reply command
    localparam int OP_ACK       = 0;
    localparam int OP_READ_BACK = 1;
    localparam int NUM_OPS      = 2;

    // data field of every acknowledge
    localparam logic [DATA_W-1:0] ACK_DATA = 32'hAAABACAD;

    // cycles cpu_reset stays high
    localparam int CPU_RESET_LEN = 4;

    // decoded frame, same bit order as the bytes on the wire
    typedef struct packed {
        logic [TYPE_W-1:0] frame_type;
        logic              toggle;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } ocd_frame_t;

endpackage

/* hdl/ocd_frame_if.sv */
`timescale 1ns/1ps

interface ocd_frame_if;
    import ocd_pkg::*;

    // one-cycle strobe, frame is only meaningful with it
    logic       valid;
    ocd_frame_t frame;
    // executor still working on the previous frame
    logic       busy;

    modport rx (
        output valid,
        output frame,
        input  busy
    );

    modport exec (
        input  valid,
        input  frame,
        output busy
    );

endinterface

/* hdl/ocd_crc16.sv */
`timescale 1ns/1ps

module ocd_crc16 (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       clear,
    input  logic                       en,
    input  logic [ocd_pkg::BYTE_W-1:0] data,
    output logic [15:0]                crc
);
    import ocd_pkg::*;

    logic [15:0] crc_next;
    logic        feedback;

    // whole byte folded in one cycle, MSB first
    always_comb begin
        crc_next = crc;
        feedback = 1'b0;
        for (int i = BYTE_W - 1; i >= 0; i--) begin
            feedback = crc_next[15] ^ data[i];
            crc_next = {crc_next[14:0], 1'b0};
            if (feedback) begin
                crc_next = crc_next ^ CRC_POLY;
            end
        end
    end

    // clear wins over a byte in the same cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            crc <= CRC_INIT;
        end else if (clear) begin
            crc <= CRC_INIT;
        end else if (en) begin
            crc <= crc_next;
        end
    end

endmodule

/* hdl/ocd_frame_rx.sv */
`timescale 1ns/1ps

module ocd_frame_rx (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       enable_in,
    input  logic [ocd_pkg::BYTE_W-1:0] data_in,
    ocd_frame_if.rx                    fr
);
    import ocd_pkg::*;

    typedef enum logic [2:0] {
        S_HUNT,
        S_SYNC_1,
        S_SYNC_0,
        S_BODY,
        S_CHECK
    } rx_state_t;

    rx_state_t             state;
    rx_state_t             next_state;
    logic                  take;
    logic                  crc_clear;
    logic                  crc_en;
    logic [15:0]           crc;
    logic [BODY_CNT_W-1:0] byte_cnt;
    logic [PAYLOAD_W-1:0]  field_sr;

    // ==========================================================
    // byte acceptance and sync hunt
    // ==========================================================

    // no new frame may start while the executor is busy
    always_comb begin
        case (state)
            S_HUNT:  take = enable_in && !fr.busy;
            S_CHECK: take = 1'b0;
            default: take = enable_in;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            S_HUNT: begin
                if (take && (data_in == SYNC_2)) begin
                    next_state = S_SYNC_1;
                end
            end
            S_SYNC_1: begin
                if (take) begin
                    next_state = (data_in == SYNC_1) ? S_SYNC_0 : S_HUNT;
                end
            end
            S_SYNC_0: begin
                if (take) begin
                    next_state = (data_in == SYNC_0) ? S_BODY : S_HUNT;
                end
            end
            S_BODY: begin
                if (take && (byte_cnt == BODY_CNT_W'(BODY_LEN - 1))) begin
                    next_state = S_CHECK;
                end
            end
            default: begin
                next_state = S_HUNT;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= S_HUNT;
            byte_cnt <= '0;
        end else begin
            state <= next_state;
            if (state != S_BODY) begin
                byte_cnt <= '0;
            end else if (take) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // ==========================================================
    // CRC over all twelve bytes
    // ==========================================================

    // register sits at init whenever we are back in hunt
    assign crc_clear = (next_state == S_HUNT);
    assign crc_en    = take && !crc_clear;

    ocd_crc16 i_crc16 (
        .clk     (clk),
        .reset_n (reset_n),
        .clear   (crc_clear),
        .en      (crc_en),
        .data    (data_in),
        .crc     (crc)
    );

    // type, address and data bytes; CRC bytes are not kept
    always_ff @(posedge clk) begin
        if ((state == S_BODY) && take && (byte_cnt < BODY_CNT_W'(FIELD_LEN))) begin
            field_sr <= {field_sr[PAYLOAD_W-BYTE_W-1:0], data_in};
        end
    end

    // check cycle follows the last byte directly
    assign fr.valid = (state == S_CHECK) && (crc == 16'h0000);
    assign fr.frame = ocd_frame_t'(field_sr);

    a_valid_single: assert property (@(posedge clk) disable iff (!reset_n)
        fr.valid |=> !fr.valid);

endmodule

/* hdl/ocd_cmd_exec.sv */
`timescale 1ns/1ps

module ocd_cmd_exec (
    input  logic                            clk,
    input  logic                            reset_n,
    ocd_frame_if.exec                       fr,
    input  logic                            pram_read_enable_in,
    input  logic [ocd_pkg::DATA_W-1:0]      pram_read_data_in,
    output logic                            pram_read_enable_out,
    output logic [ocd_pkg::WORD_ADDR_W-1:0] pram_read_addr_out,
    output logic                            pram_write_enable_out,
    output logic [ocd_pkg::WORD_ADDR_W-1:0] pram_write_addr_out,
    output logic [ocd_pkg::DATA_W-1:0]      pram_write_data_out,
    output logic                            cpu_reset,
    output logic                            uart_sel,
    output logic                            reply_enable_out,
    output logic [ocd_pkg::NUM_OPS-1:0]     reply_debug_cmd,
    output logic [ocd_pkg::PAYLOAD_W-1:0]   reply_payload,
    input  logic                            reply_done
);
    import ocd_pkg::*;

    typedef enum logic [1:0] {
        E_IDLE,
        E_FLUSH,
        E_READ_WAIT,
        E_REPLY
    } exec_state_t;

    exec_state_t              state;
    logic                     start;
    logic                     read_back;
    logic [CPU_RESET_LEN-1:0] reset_sr;

    assign start     = fr.valid && (state == E_IDLE);
    assign read_back = (state == E_READ_WAIT) && pram_read_enable_in;

    // anything but idle holds off the receiver
    assign fr.busy = (state != E_IDLE);

    // stretcher is loaded with ones and drains from the bottom
    assign cpu_reset = reset_sr[0];

    // ==========================================================
    // dispatch and reply handshake
    // ==========================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state                 <= E_IDLE;
            pram_write_enable_out <= 1'b0;
            pram_read_enable_out  <= 1'b0;
            reply_enable_out      <= 1'b0;
            reply_debug_cmd       <= '0;
            uart_sel              <= 1'b0;
            reset_sr              <= '0;
        end else begin
            pram_write_enable_out <= 1'b0;
            pram_read_enable_out  <= 1'b0;
            reset_sr              <= {1'b0, reset_sr[CPU_RESET_LEN-1:1]};

            case (state)
                E_IDLE: begin
                    if (start) begin
                        case (fr.frame.frame_type)
                            TYPE_WRITE_NOACK: begin
                                pram_write_enable_out <= 1'b1;
                                state                 <= E_FLUSH;
                            end
                            TYPE_WRITE_ACK: begin
                                pram_write_enable_out <= 1'b1;
                                reply_enable_out      <= 1'b1;
                                reply_debug_cmd       <= NUM_OPS'(1) << OP_ACK;
                                state                 <= E_REPLY;
                            end
                            TYPE_READ: begin
                                pram_read_enable_out <= 1'b1;
                                state                <= E_READ_WAIT;
                            end
                            TYPE_CPU_RESET: begin
                                reset_sr         <= '1;
                                reply_enable_out <= 1'b1;
                                reply_debug_cmd  <= NUM_OPS'(1) << OP_ACK;
                                state            <= E_REPLY;
                            end
                            TYPE_UART_SEL: begin
                                // data bit 1 set hands the UART to the debugger
                                uart_sel <= fr.frame.data[1];
                                state    <= E_FLUSH;
                            end
                            default: begin
                                state <= E_FLUSH;
                            end
                        endcase
                    end
                end
                E_FLUSH: begin
                    state <= E_IDLE;
                end
                E_READ_WAIT: begin
                    if (read_back) begin
                        reply_enable_out <= 1'b1;
                        reply_debug_cmd  <= NUM_OPS'(1) << OP_READ_BACK;
                        state            <= E_REPLY;
                    end
                end
                E_REPLY: begin
                    if (reply_done) begin
                        reply_enable_out <= 1'b0;
                        state            <= E_IDLE;
                    end
                end
                default: begin
                    state <= E_IDLE;
                end
            endcase
        end
    end

    // ==========================================================
    // RAM port and reply payload
    // ==========================================================
    always_ff @(posedge clk) begin
        if (start) begin
            pram_write_addr_out <= fr.frame.addr[ADDR_W-1:ADDR_W-WORD_ADDR_W];
            pram_write_data_out <= fr.frame.data;
            pram_read_addr_out  <= fr.frame.addr[ADDR_W-1:ADDR_W-WORD_ADDR_W];
            // header plus ack data until a read-back replaces the data
            reply_payload <= {fr.frame.frame_type, fr.frame.toggle, fr.frame.addr, ACK_DATA};
        end else if (read_back) begin
            reply_payload <= {reply_payload[PAYLOAD_W-1:DATA_W], pram_read_data_in};
        end
    end

    a_rw_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(pram_read_enable_out && pram_write_enable_out));

    a_reply_hold: assert property (@(posedge clk) disable iff (!reset_n)
        reply_enable_out && !reply_done |=>
            reply_enable_out && $stable(reply_payload) && $stable(reply_debug_cmd));

endmodule

/* hdl/debug_coprocessor.sv */
`timescale 1ns/1ps

module debug_coprocessor (
    input  logic                            clk,
    input  logic                            reset_n,

    // byte stream from the debug UART
    input  logic                            enable_in,
    input  logic [ocd_pkg::BYTE_W-1:0]      debug_data_in,

    // program RAM
    output logic                            pram_read_enable_out,
    output logic [ocd_pkg::WORD_ADDR_W-1:0] pram_read_addr_out,
    input  logic                            pram_read_enable_in,
    input  logic [ocd_pkg::DATA_W-1:0]      pram_read_data_in,
    output logic                            pram_write_enable_out,
    output logic [ocd_pkg::WORD_ADDR_W-1:0] pram_write_addr_out,
    output logic [ocd_pkg::DATA_W-1:0]      pram_write_data_out,

    // reply channel
    output logic                            reply_enable_out,
    output logic [ocd_pkg::NUM_OPS-1:0]     reply_debug_cmd,
    output logic [ocd_pkg::PAYLOAD_W-1:0]   reply_payload,
    input  logic                            reply_done,

    output logic                            cpu_reset,
    output logic                            debug_uart_tx_sel_ocd1_cpu0
);

    ocd_frame_if frame_bus ();

    // framing, sync and CRC
    ocd_frame_rx i_frame_rx (
        .clk       (clk),
        .reset_n   (reset_n),
        .enable_in (enable_in),
        .data_in   (debug_data_in),
        .fr        (frame_bus.rx)
    );

    // one command at a time
    ocd_cmd_exec i_cmd_exec (
        .clk                   (clk),
        .reset_n               (reset_n),
        .fr                    (frame_bus.exec),
        .pram_read_enable_in   (pram_read_enable_in),
        .pram_read_data_in     (pram_read_data_in),
        .pram_read_enable_out  (pram_read_enable_out),
        .pram_read_addr_out    (pram_read_addr_out),
        .pram_write_enable_out (pram_write_enable_out),
        .pram_write_addr_out   (pram_write_addr_out),
        .pram_write_data_out   (pram_write_data_out),
        .cpu_reset             (cpu_reset),
        .uart_sel              (debug_uart_tx_sel_ocd1_cpu0),
        .reply_enable_out      (reply_enable_out),
        .reply_debug_cmd       (reply_debug_cmd),
        .reply_payload         (reply_payload),
        .reply_done            (reply_done)
    );

endmodule

/* verification/tb_frames.svh */
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

// ============================================================
// stimulus table
// ============================================================
typedef struct packed {
    logic [TYPE_W-1:0]  frame_type;
    logic               toggle;
    logic [ADDR_W-1:0]  addr;
    logic [DATA_W-1:0]  data;
    logic [4:0]         flags;
    logic [NUM_OPS-1:0] exp_cmd;
} row_t;

// corrupt CRC flag on top, then the expected write, read, reset and select
localparam int F_BAD   = 4;
localparam int F_WRITE = 3;
localparam int F_READ  = 2;
localparam int F_RESET = 1;
localparam int F_SEL   = 0;

localparam int NUM_ROWS = 14;
// one-hot reply command with ack in bit 0 and read-back in bit 1
localparam logic [NUM_OPS-1:0] R_NONE = 2'b00;
localparam logic [NUM_OPS-1:0] R_ACK  = 2'b01;
localparam logic [NUM_OPS-1:0] R_READ = 2'b10;

row_t              rows     [NUM_ROWS];
string             row_name [NUM_ROWS];
int                row_fill = 0;
logic [BYTE_W-1:0] tx_bytes [FRAME_LEN];

task automatic add_row(input string name, input logic [TYPE_W-1:0] frame_type,
                       input logic toggle, input logic [ADDR_W-1:0] addr,
                       input logic [DATA_W-1:0] data, input logic [4:0] flags,
                       input logic [NUM_OPS-1:0] exp_cmd);
    row_name[row_fill] = name;
    rows[row_fill]     = {frame_type, toggle, addr, data, flags, exp_cmd};
    row_fill++;
endtask

task automatic load_table();
    // name, type, toggle, byte address, data, flags, expected reply
    add_row("wr_noack", TYPE_WRITE_NOACK, 1'b0, 16'h0010, 32'h11223344, 5'b01000, R_NONE);
    add_row("wr_ack", TYPE_WRITE_ACK, 1'b1, 16'h0026, 32'hCAFE0001, 5'b01000, R_ACK);
    add_row("rd_first", TYPE_READ, 1'b0, 16'h0012, 32'h00000000, 5'b00100, R_READ);
    add_row("rd_second", TYPE_READ, 1'b1, 16'h0024, 32'h00000000, 5'b00100, R_READ);
    add_row("bad_crc_wr", TYPE_WRITE_ACK, 1'b0, 16'h0010, 32'hDEADBEEF, 5'b10000, R_NONE);
    add_row("rd_after_bad", TYPE_READ, 1'b1, 16'h0010, 32'h00000000, 5'b00100, R_READ);
    add_row("rd_unwritten", TYPE_READ, 1'b0, 16'hBEEC, 32'h00000000, 5'b00100, R_READ);
    add_row("cpu_reset", TYPE_CPU_RESET, 1'b1, 16'h0000, 32'h00000000, 5'b00010, R_ACK);
    add_row("uart_on", TYPE_UART_SEL, 1'b0, 16'h0000, 32'h00000002, 5'b00001, R_NONE);
    add_row("bad_crc_uart", TYPE_UART_SEL, 1'b0, 16'h0000, 32'h00000000, 5'b10001, R_NONE);
    add_row("uart_off", TYPE_UART_SEL, 1'b1, 16'h0000, 32'hFFFFFFFD, 5'b00000, R_NONE);
    add_row("unknown_type", 7'h33, 1'b0, 16'h0040, 32'h55555555, 5'b00000, R_NONE);
    add_row("wr_noack_top", TYPE_WRITE_NOACK, 1'b1, 16'hFFFE, 32'h0BADF00D, 5'b01000, R_NONE);
    add_row("rd_top", TYPE_READ, 1'b0, 16'hFFFC, 32'h00000000, 5'b00100, R_READ);
endtask

// folds one byte into a CCITT CRC MSB first
function automatic logic [15:0] crc_update(input logic [15:0] crc, input logic [7:0] value);
    logic [15:0] c;
    c = crc ^ {value, 8'h00};
    for (int i = 0; i < 8; i++) begin
        c = c[15] ? ((c << 1) ^ CRC_POLY) : (c << 1);
    end
    return c;
endfunction

task automatic build_frame(input int idx);
    logic [15:0] crc;
    crc         = CRC_INIT;
    tx_bytes[0] = SYNC_2;
    tx_bytes[1] = SYNC_1;
    tx_bytes[2] = SYNC_0;
    tx_bytes[3] = {rows[idx].frame_type, rows[idx].toggle};
    tx_bytes[4] = rows[idx].addr[15:8];
    tx_bytes[5] = rows[idx].addr[7:0];
    for (int k = 0; k < 4; k++) begin
        tx_bytes[6 + k] = rows[idx].data[31 - 8 * k -: 8];
    end
    for (int k = 0; k < FRAME_LEN - 2; k++) begin
        crc = crc_update(crc, tx_bytes[k]);
    end
    tx_bytes[10] = crc[15:8];
    // a corrupt row flips one bit of the low CRC byte
    tx_bytes[11] = crc[7:0] ^ {7'b0, rows[idx].flags[F_BAD]};
endtask

`endif

/* verification/tb_debug_coprocessor.sv */
`timescale 1ns/1ps

module tb_debug_coprocessor;
    import ocd_pkg::*;

    `include "tb_frames.svh"

    localparam int SETTLE_CYCLES = 12;
    localparam int REPLY_LIMIT   = 150;

    logic                   clk = 1'b0;
    logic                   reset_n;
    logic                   enable_in;
    logic [BYTE_W-1:0]      debug_data_in;
    logic                   pram_read_enable_out;
    logic [WORD_ADDR_W-1:0] pram_read_addr_out;
    logic                   pram_read_enable_in;
    logic [DATA_W-1:0]      pram_read_data_in;
    logic                   pram_write_enable_out;
    logic [WORD_ADDR_W-1:0] pram_write_addr_out;
    logic [DATA_W-1:0]      pram_write_data_out;
    logic                   reply_enable_out;
    logic [NUM_OPS-1:0]     reply_debug_cmd;
    logic [PAYLOAD_W-1:0]   reply_payload;
    logic                   reply_done;
    logic                   cpu_reset;
    logic                   debug_uart_tx_sel_ocd1_cpu0;

    // what the RAM holds, and what the table says it should hold
    logic [DATA_W-1:0]      ram_model [int];
    logic [DATA_W-1:0]      exp_mem [int];

    int                     errors = 0;
    int                     checks = 0;
    int                     write_cnt = 0;
    int                     read_cnt = 0;
    int                     reply_cnt = 0;
    int                     reset_cycles = 0;
    int                     reset_rises = 0;
    int                     hold_errors = 0;
    logic                   cpu_reset_q = 1'b0;
    logic [WORD_ADDR_W-1:0] last_waddr;
    logic [DATA_W-1:0]      last_wdata;
    logic [WORD_ADDR_W-1:0] last_raddr;
    logic [NUM_OPS-1:0]     reply_cmd_q;
    logic [PAYLOAD_W-1:0]   reply_payload_q;

    debug_coprocessor i_debug_coprocessor (.*);

    always #5 clk = ~clk;

    // unwritten words
    function automatic logic [DATA_W-1:0] fill_word(input logic [WORD_ADDR_W-1:0] wa);
        return {2'b10, wa, 2'b01, ~wa};
    endfunction

    function automatic logic [DATA_W-1:0] expected_word(input logic [WORD_ADDR_W-1:0] wa);
        if (exp_mem.exists(int'(wa))) begin
            return exp_mem[int'(wa)];
        end
        return fill_word(wa);
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %0h, actual %0h", what, expected, actual);
        end
    endtask

    // ============================================================
    // monitors and bus models
    // ============================================================
    always @(posedge clk) begin
        if (pram_write_enable_out) begin
            write_cnt++;
            last_waddr = pram_write_addr_out;
            last_wdata = pram_write_data_out;
            ram_model[int'(pram_write_addr_out)] = pram_write_data_out;
        end
        if (pram_read_enable_out) begin
            read_cnt++;
            last_raddr = pram_read_addr_out;
        end
        if (cpu_reset) begin
            reset_cycles++;
        end
        if (cpu_reset && !cpu_reset_q) begin
            reset_rises++;
        end
        cpu_reset_q = cpu_reset;
    end

    // read answer after 1 to 5 cycles
    initial begin
        int                     delay;
        logic [WORD_ADDR_W-1:0] wa;
        logic [DATA_W-1:0]      word;
        pram_read_enable_in <= 1'b0;
        pram_read_data_in   <= '0;
        forever begin
            @(posedge clk);
            if (pram_read_enable_out) begin
                wa    = pram_read_addr_out;
                word  = ram_model.exists(int'(wa)) ? ram_model[int'(wa)] : fill_word(wa);
                delay = int'($urandom_range(5, 1));
                repeat (delay - 1) @(posedge clk);
                pram_read_enable_in <= 1'b1;
                pram_read_data_in   <= word;
                @(posedge clk);
                pram_read_enable_in <= 1'b0;
            end
        end
    end

    // reply sink, done after 0 to 4 cycles
    initial begin
        int delay;
        reply_done <= 1'b0;
        forever begin
            @(posedge clk);
            if (reply_enable_out) begin
                reply_cmd_q     = reply_debug_cmd;
                reply_payload_q = reply_payload;
                delay           = int'($urandom_range(4, 0));
                repeat (delay) begin
                    @(posedge clk);
                    if (!reply_enable_out || reply_debug_cmd !== reply_cmd_q ||
                        reply_payload !== reply_payload_q) begin
                        hold_errors++;
                    end
                end
                reply_done <= 1'b1;
                @(posedge clk);
                reply_done <= 1'b0;
                reply_cnt++;
            end
        end
    end

    // ============================================================
    // stimulus
    // ============================================================
    task automatic send_byte(input logic [BYTE_W-1:0] value);
        int gap;
        gap = int'($urandom_range(3, 0));
        repeat (gap) begin
            @(posedge clk);
            enable_in <= 1'b0;
        end
        @(posedge clk);
        enable_in     <= 1'b1;
        debug_data_in <= value;
    endtask

    task automatic run_row(input int idx);
        row_t                   row;
        string                  nm;
        logic [WORD_ADDR_W-1:0] wa;
        logic [DATA_W-1:0]      exp_data;
        int                     write0;
        int                     read0;
        int                     reply0;
        int                     cycles0;
        int                     rises0;
        int                     hold0;
        int                     waited;
        row      = rows[idx];
        nm       = row_name[idx];
        wa       = row.addr[ADDR_W-1:2];
        exp_data = (row.exp_cmd == R_ACK) ? ACK_DATA : expected_word(wa);
        write0   = write_cnt;
        read0    = read_cnt;
        reply0   = reply_cnt;
        cycles0  = reset_cycles;
        rises0   = reset_rises;
        hold0    = hold_errors;
        waited   = 0;
        build_frame(idx);
        for (int b = 0; b < FRAME_LEN; b++) begin
            send_byte(tx_bytes[b]);
        end
        @(posedge clk);
        enable_in <= 1'b0;
        if (row.exp_cmd != R_NONE) begin
            while (reply_cnt == reply0 && waited < REPLY_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            if (reply_cnt == reply0) begin
                errors++;
                $display("row %s: the DUT gave no reply within %0d cycles", nm, REPLY_LIMIT);
            end
        end
        repeat (SETTLE_CYCLES) @(posedge clk);

        check_value({nm, " write strobes"}, 64'(row.flags[F_WRITE]), 64'(write_cnt - write0));
        if (row.flags[F_WRITE]) begin
            check_value({nm, " write addr"}, 64'(wa), 64'(last_waddr));
            check_value({nm, " write data"}, 64'(row.data), 64'(last_wdata));
            exp_mem[int'(wa)] = row.data;
        end
        check_value({nm, " read strobes"}, 64'(row.flags[F_READ]), 64'(read_cnt - read0));
        if (row.flags[F_READ]) begin
            check_value({nm, " read addr"}, 64'(wa), 64'(last_raddr));
        end
        check_value({nm, " replies"}, 64'(row.exp_cmd != R_NONE), 64'(reply_cnt - reply0));
        if (row.exp_cmd != R_NONE) begin
            check_value({nm, " reply cmd"}, 64'(row.exp_cmd), 64'(reply_cmd_q));
            check_value({nm, " reply payload"},
                        64'({row.frame_type, row.toggle, row.addr, exp_data}),
                        64'(reply_payload_q));
            check_value({nm, " reply hold"}, 64'(0), 64'(hold_errors - hold0));
        end
        check_value({nm, " reset cycles"}, 64'(row.flags[F_RESET] ? CPU_RESET_LEN : 0),
                    64'(reset_cycles - cycles0));
        check_value({nm, " reset pulses"}, 64'(row.flags[F_RESET]), 64'(reset_rises - rises0));
        check_value({nm, " uart select"}, 64'(row.flags[F_SEL]),
                    64'(debug_uart_tx_sel_ocd1_cpu0));
    endtask

    initial begin
        void'($urandom(673));
        reset_n       <= 1'b0;
        enable_in     <= 1'b0;
        debug_data_in <= '0;
        load_table();
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        repeat (4) @(posedge clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // generous budget per table row
    initial begin
        repeat (NUM_ROWS * 200) @(posedge clk);
        $display("watchdog: the table did not finish within %0d cycles", NUM_ROWS * 200);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Something failed");
        $finish;
    end

endmodule

/* Makefile */
TOP := tb_debug_coprocessor

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -Mdir obj_dir

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

/* verilog.f */
+incdir+verification
hdl/ocd_pkg.sv
hdl/ocd_frame_if.sv
hdl/ocd_crc16.sv
hdl/ocd_frame_rx.sv
hdl/ocd_cmd_exec.sv
hdl/debug_coprocessor.sv
verification/tb_debug_coprocessor.sv
